//--- common/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // byte address and word layout
    localparam int addr_width = 32;
    localparam int byte_bits = 2;

    typedef logic [31:0] word_t;

    // port 2 word in the upper half
    typedef struct packed {
        word_t word_2;
        word_t word_1;
    } fetch_pair_t;

    // maintenance input from the coprocessor
    typedef enum logic [2:0] {
        OP_FETCH,
        OP_INDEX_INVALID,
        OP_HIT_INVALID,
        OP_INDEX_STORE_TAG,
        OP_NONE
    } icache_op_t;

    typedef enum logic [1:0] {
        INIT,
        IDLE,
        REFILL_1,
        REFILL_2
    } icache_state_t;

    // two ways, so one bit
    typedef logic way_t;

endpackage

`default_nettype wire

//--- files.f
common/icache_pkg.sv
icache/icache_tag_array.sv
icache/icache_data_array.sv
icache/icache_plru.sv
icache/icache_ctrl.sv
icache/icache.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv

//--- icache/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int set_count = 16,
    parameter int line_words = 4
) (
    input  wire logic                               clk,
    input  wire logic                               resetn,
    input  wire logic                               req_valid,
    input  wire logic [icache_pkg::addr_width-1:0]  req_addr,
    input  wire logic                               req2_valid,
    input  wire logic [icache_pkg::addr_width-1:0]  req2_addr,
    input  icache_pkg::icache_op_t                  op,
    input  icache_pkg::word_t                       tag_lo,
    output logic                                    addr_ok,
    output logic                                    data_ok,
    output icache_pkg::fetch_pair_t                 rdata,
    output logic                                    mem_valid,
    output logic [icache_pkg::addr_width-1:0]       mem_addr,
    input  wire logic                               mem_ready,
    input  wire logic                               mem_last,
    input  icache_pkg::word_t                       mem_data
);

    localparam int offset_bits = $clog2(line_words);
    localparam int index_bits = $clog2(set_count);
    localparam int tag_lsb = icache_pkg::byte_bits + offset_bits + index_bits;
    localparam int tag_bits = icache_pkg::addr_width - tag_lsb;
    localparam int data_addr_bits = 1 + index_bits + offset_bits;

    logic hit_1;
    logic hit_2;
    icache_pkg::way_t hit_way_1;
    icache_pkg::way_t hit_way_2;
    icache_pkg::way_t victim_1;
    icache_pkg::way_t victim_2;
    logic plru_update;
    logic tag_wr_en;
    logic [index_bits-1:0] tag_wr_index;
    icache_pkg::way_t tag_wr_way;
    logic [tag_bits-1:0] tag_wr_tag;
    logic tag_wr_valid;
    logic [data_addr_bits-1:0] data_addr_2;
    logic data_wr_en_2;
    icache_pkg::word_t data_wdata_2;

    icache_ctrl #(
        .set_count(set_count),
        .line_words(line_words)
    ) i_ctrl (
        .clk(clk),
        .resetn(resetn),
        .req_valid(req_valid),
        .req_addr(req_addr),
        .req2_valid(req2_valid),
        .req2_addr(req2_addr),
        .op(op),
        .tag_lo(tag_lo),
        .hit_1(hit_1),
        .hit_2(hit_2),
        .hit_way_1(hit_way_1),
        .hit_way_2(hit_way_2),
        .victim_1(victim_1),
        .victim_2(victim_2),
        .mem_ready(mem_ready),
        .mem_last(mem_last),
        .mem_data(mem_data),
        .addr_ok(addr_ok),
        .data_ok(data_ok),
        .plru_update(plru_update),
        .tag_wr_en(tag_wr_en),
        .tag_wr_index(tag_wr_index),
        .tag_wr_way(tag_wr_way),
        .tag_wr_tag(tag_wr_tag),
        .tag_wr_valid(tag_wr_valid),
        .data_addr_2(data_addr_2),
        .data_wr_en_2(data_wr_en_2),
        .data_wdata_2(data_wdata_2),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr)
    );

    icache_tag_array #(
        .set_count(set_count),
        .line_words(line_words)
    ) i_tag_array (
        .clk(clk),
        .resetn(resetn),
        .rd_addr_1(req_addr),
        .rd_addr_2(req2_addr),
        .wr_en(tag_wr_en),
        .wr_index(tag_wr_index),
        .wr_way(tag_wr_way),
        .wr_tag(tag_wr_tag),
        .wr_valid(tag_wr_valid),
        .hit_1(hit_1),
        .hit_2(hit_2),
        .hit_way_1(hit_way_1),
        .hit_way_2(hit_way_2)
    );

    icache_plru #(
        .set_count(set_count),
        .line_words(line_words)
    ) i_plru (
        .clk(clk),
        .resetn(resetn),
        .update(plru_update),
        .addr_1(req_addr),
        .addr_2(req2_addr),
        .hit_way_1(hit_way_1),
        .hit_way_2(hit_way_2),
        .valid_2(req2_valid),
        .victim_1(victim_1),
        .victim_2(victim_2)
    );

    // port 1 reads straight from the hit way
    icache_data_array #(
        .set_count(set_count),
        .line_words(line_words)
    ) i_data_array (
        .clk(clk),
        .addr_1({hit_way_1, req_addr[tag_lsb-1:icache_pkg::byte_bits]}),
        .addr_2(data_addr_2),
        .wr_en_2(data_wr_en_2),
        .wdata_2(data_wdata_2),
        .rdata_1(rdata.word_1),
        .rdata_2(rdata.word_2)
    );

endmodule

`default_nettype wire

//--- icache/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
    parameter int set_count = 16,
    parameter int line_words = 4
) (
    input  wire logic                               clk,
    input  wire logic                               resetn,
    input  wire logic                               req_valid,
    input  wire logic [icache_pkg::addr_width-1:0]  req_addr,
    input  wire logic                               req2_valid,
    input  wire logic [icache_pkg::addr_width-1:0]  req2_addr,
    input  icache_pkg::icache_op_t                  op,
    input  icache_pkg::word_t                       tag_lo,
    input  wire logic                               hit_1,
    input  wire logic                               hit_2,
    input  icache_pkg::way_t                        hit_way_1,
    input  icache_pkg::way_t                        hit_way_2,
    input  icache_pkg::way_t                        victim_1,
    input  icache_pkg::way_t                        victim_2,
    input  wire logic                               mem_ready,
    input  wire logic                               mem_last,
    input  icache_pkg::word_t                       mem_data,
    output logic                                    addr_ok,
    output logic                                    data_ok,
    output logic                                    plru_update,
    output logic                                    tag_wr_en,
    output logic [$clog2(set_count)-1:0]            tag_wr_index,
    output icache_pkg::way_t                        tag_wr_way,
    output logic [icache_pkg::addr_width-$clog2(set_count)-$clog2(line_words)
                  -icache_pkg::byte_bits-1:0]       tag_wr_tag,
    output logic                                    tag_wr_valid,
    output logic [$clog2(2*set_count*line_words)-1:0] data_addr_2,
    output logic                                    data_wr_en_2,
    output icache_pkg::word_t                       data_wdata_2,
    output logic                                    mem_valid,
    output logic [icache_pkg::addr_width-1:0]       mem_addr
);

    localparam int offset_bits = $clog2(line_words);
    localparam int index_bits = $clog2(set_count);
    localparam int index_lsb = icache_pkg::byte_bits + offset_bits;
    localparam int tag_lsb = index_lsb + index_bits;
    localparam int tag_bits = icache_pkg::addr_width - tag_lsb;

    icache_pkg::icache_state_t state;
    logic [index_bits-1:0] sweep_cnt;
    logic [offset_bits-1:0] word_cnt;
    icache_pkg::way_t refill_way;
    logic refilling;
    logic fetch_hit;
    logic [icache_pkg::addr_width-1:0] refill_addr;
    logic [index_bits-1:0] refill_index;
    logic [index_bits-1:0] index_1;
    logic [tag_bits-1:0] tag_1;

    assign index_1 = req_addr[tag_lsb-1:index_lsb];
    assign tag_1 = req_addr[icache_pkg::addr_width-1:tag_lsb];
    assign refilling = (state == icache_pkg::REFILL_1) || (state == icache_pkg::REFILL_2);
    assign refill_addr = (state == icache_pkg::REFILL_2) ? req2_addr : req_addr;
    assign refill_index = refill_addr[tag_lsb-1:index_lsb];
    assign fetch_hit = hit_1 && (!req2_valid || hit_2);

    always_comb begin
        addr_ok = 1'b0;
        if (state == icache_pkg::IDLE && req_valid) begin
            case (op)
                icache_pkg::OP_FETCH:           addr_ok = fetch_hit;
                icache_pkg::OP_INDEX_INVALID,
                icache_pkg::OP_HIT_INVALID,
                icache_pkg::OP_INDEX_STORE_TAG: addr_ok = 1'b1;
                default:                        addr_ok = 1'b0;
            endcase
        end
    end

    assign plru_update = addr_ok && (op == icache_pkg::OP_FETCH);

    // tag write port, defaults suit the index ops
    always_comb begin
        tag_wr_en = 1'b0;
        tag_wr_index = index_1;
        tag_wr_way = req_addr[tag_lsb];
        tag_wr_tag = tag_1;
        tag_wr_valid = 1'b0;
        case (state)
            icache_pkg::INIT: begin
                tag_wr_en = 1'b1;
                tag_wr_index = sweep_cnt;
                tag_wr_way = 1'b0;
                tag_wr_tag = '0;
            end
            icache_pkg::REFILL_1, icache_pkg::REFILL_2: begin
                // tag goes in with the last word
                tag_wr_en = mem_ready && mem_last;
                tag_wr_index = refill_index;
                tag_wr_way = refill_way;
                tag_wr_tag = refill_addr[icache_pkg::addr_width-1:tag_lsb];
                tag_wr_valid = 1'b1;
            end
            default: begin
                if (addr_ok) begin
                    case (op)
                        icache_pkg::OP_INDEX_INVALID: begin
                            tag_wr_en = 1'b1;
                        end
                        icache_pkg::OP_HIT_INVALID: begin
                            tag_wr_en = hit_1;
                            tag_wr_way = hit_way_1;
                        end
                        icache_pkg::OP_INDEX_STORE_TAG: begin
                            tag_wr_en = 1'b1;
                            tag_wr_tag = tag_lo[icache_pkg::addr_width-1 -: tag_bits];
                            tag_wr_valid = tag_lo[0];
                        end
                        default: begin
                            tag_wr_en = 1'b0;
                        end
                    endcase
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= icache_pkg::INIT;
            sweep_cnt <= '0;
            word_cnt <= '0;
            data_ok <= 1'b0;
        end else begin
            data_ok <= addr_ok;
            case (state)
                icache_pkg::INIT: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_cnt == index_bits'(set_count - 1)) begin
                        state <= icache_pkg::IDLE;
                    end
                end
                icache_pkg::IDLE: begin
                    word_cnt <= '0;
                    if (req_valid && op == icache_pkg::OP_FETCH) begin
                        if (!hit_1) begin
                            state <= icache_pkg::REFILL_1;
                        end else if (req2_valid && !hit_2) begin
                            state <= icache_pkg::REFILL_2;
                        end
                    end
                end
                icache_pkg::REFILL_1, icache_pkg::REFILL_2: begin
                    if (mem_ready) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (mem_last) begin
                            state <= icache_pkg::IDLE;
                        end
                    end
                end
                default: begin
                    state <= icache_pkg::IDLE;
                end
            endcase
        end
    end

    // victim captured while idle, held through the refill
    always_ff @(posedge clk) begin
        if (state == icache_pkg::IDLE) begin
            refill_way <= hit_1 ? victim_2 : victim_1;
        end
    end

    assign data_wr_en_2 = refilling && mem_ready;
    assign data_wdata_2 = mem_data;
    assign data_addr_2 = refilling ? {refill_way, refill_index, word_cnt}
                                   : {hit_way_2, req2_addr[tag_lsb-1:icache_pkg::byte_bits]};

    assign mem_valid = refilling;
    assign mem_addr = {refill_addr[icache_pkg::addr_width-1:index_lsb], {index_lsb{1'b0}}};

endmodule

`default_nettype wire

//--- icache/icache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_array #(
    parameter int set_count = 16,
    parameter int line_words = 4
) (
    input  wire logic                                   clk,
    input  wire logic [$clog2(2*set_count*line_words)-1:0] addr_1,
    input  wire logic [$clog2(2*set_count*line_words)-1:0] addr_2,
    input  wire logic                                   wr_en_2,
    input  icache_pkg::word_t                           wdata_2,
    output icache_pkg::word_t                           rdata_1,
    output icache_pkg::word_t                           rdata_2
);

    // address is {way, set, word offset}
    localparam int depth = 2 * set_count * line_words;

    icache_pkg::word_t mem [depth];

    always_ff @(posedge clk) begin
        rdata_1 <= mem[addr_1];
    end

    // port 2 reads old data on a write
    always_ff @(posedge clk) begin
        rdata_2 <= mem[addr_2];
        if (wr_en_2) begin
            mem[addr_2] <= wdata_2;
        end
    end

endmodule

`default_nettype wire

//--- icache/icache_plru.sv
`timescale 1ns/1ps
`default_nettype none

module icache_plru #(
    parameter int set_count = 16,
    parameter int line_words = 4
) (
    input  wire logic                               clk,
    input  wire logic                               resetn,
    input  wire logic                               update,
    input  wire logic [icache_pkg::addr_width-1:0]  addr_1,
    input  wire logic [icache_pkg::addr_width-1:0]  addr_2,
    input  icache_pkg::way_t                        hit_way_1,
    input  icache_pkg::way_t                        hit_way_2,
    input  wire logic                               valid_2,
    output icache_pkg::way_t                        victim_1,
    output icache_pkg::way_t                        victim_2
);

    localparam int index_bits = $clog2(set_count);
    localparam int index_lsb = icache_pkg::byte_bits + $clog2(line_words);

    logic [set_count-1:0] lru;
    logic [index_bits-1:0] index_1;
    logic [index_bits-1:0] index_2;

    assign index_1 = addr_1[index_lsb+index_bits-1:index_lsb];
    assign index_2 = addr_2[index_lsb+index_bits-1:index_lsb];

    // point at the way not just used, port 2 last so it wins
    always_ff @(posedge clk) begin
        if (resetn) begin
            lru <= '0;
        end else if (update) begin
            lru[index_1] <= ~hit_way_1;
            if (valid_2) begin
                lru[index_2] <= ~hit_way_2;
            end
        end
    end

    assign victim_1 = lru[index_1];
    // same set: keep the line port 1 is reading
    assign victim_2 = (index_1 == index_2) ? ~hit_way_1 : lru[index_2];

endmodule

`default_nettype wire

//--- icache/icache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array #(
    parameter int set_count = 16,
    parameter int line_words = 4
) (
    input  wire logic                               clk,
    input  wire logic                               resetn,
    input  wire logic [icache_pkg::addr_width-1:0]  rd_addr_1,
    input  wire logic [icache_pkg::addr_width-1:0]  rd_addr_2,
    input  wire logic                               wr_en,
    input  wire logic [$clog2(set_count)-1:0]       wr_index,
    input  icache_pkg::way_t                        wr_way,
    input  wire logic [icache_pkg::addr_width-$clog2(set_count)-$clog2(line_words)
                       -icache_pkg::byte_bits-1:0]  wr_tag,
    input  wire logic                               wr_valid,
    output logic                                    hit_1,
    output logic                                    hit_2,
    output icache_pkg::way_t                        hit_way_1,
    output icache_pkg::way_t                        hit_way_2
);

    localparam int offset_bits = $clog2(line_words);
    localparam int index_bits = $clog2(set_count);
    localparam int index_lsb = icache_pkg::byte_bits + offset_bits;
    localparam int tag_lsb = index_lsb + index_bits;
    localparam int tag_bits = icache_pkg::addr_width - tag_lsb;

    logic [tag_bits-1:0] tag_mem [2][set_count];
    logic [1:0] valid [set_count];

    logic [index_bits-1:0] index_1;
    logic [index_bits-1:0] index_2;
    logic [tag_bits-1:0] tag_1;
    logic [tag_bits-1:0] tag_2;
    logic [1:0] match_1;
    logic [1:0] match_2;

    assign index_1 = rd_addr_1[tag_lsb-1:index_lsb];
    assign index_2 = rd_addr_2[tag_lsb-1:index_lsb];
    assign tag_1 = rd_addr_1[icache_pkg::addr_width-1:tag_lsb];
    assign tag_2 = rd_addr_2[icache_pkg::addr_width-1:tag_lsb];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int i = 0; i < set_count; i++) begin
                valid[i] <= 2'b00;
            end
        end else if (wr_en) begin
            valid[wr_index][wr_way] <= wr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_way][wr_index] <= wr_tag;
        end
    end

    // compare both ways for each port
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            match_1[w] = valid[index_1][w] && (tag_mem[w][index_1] == tag_1);
            match_2[w] = valid[index_2][w] && (tag_mem[w][index_2] == tag_2);
        end
    end

    assign hit_1 = |match_1;
    assign hit_2 = |match_2;
    // at most one way matches
    assign hit_way_1 = match_1[1];
    assign hit_way_2 = match_2[1];

endmodule

`default_nettype wire

//--- testbench/icache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model #(
    parameter int line_words = 4
) (
    input  wire logic               clk,
    input  wire logic               mem_valid,
    input  wire logic [31:0]        mem_addr,
    input  wire logic               stall,
    output logic                    mem_ready,
    output logic                    mem_last,
    output icache_pkg::word_t       mem_data,
    output logic [31:0]             refill_count
);

    // index of the word on mem_data
    logic [31:0] word_cnt;

    // each word is its own address under a fixed pattern
    function automatic icache_pkg::word_t word_at(input logic [31:0] addr);
        return addr ^ 32'hc0de0000;
    endfunction

    initial begin
        mem_ready = 1'b0;
        mem_last = 1'b0;
        mem_data = '0;
        refill_count = '0;
        word_cnt = '0;
    end

    always @(posedge clk) begin : respond
        logic [31:0] next_cnt;
        if (mem_valid !== 1'b1) begin
            word_cnt <= '0;
            mem_ready <= 1'b0;
            mem_last <= 1'b0;
        end else if (mem_ready && mem_last) begin
            // last word taken on this edge, line complete
            refill_count <= refill_count + 1;
            word_cnt <= '0;
            mem_ready <= 1'b0;
            mem_last <= 1'b0;
        end else begin
            next_cnt = mem_ready ? word_cnt + 1 : word_cnt;
            word_cnt <= next_cnt;
            mem_ready <= !stall;
            mem_last <= (next_cnt == line_words - 1);
            mem_data <= word_at(mem_addr + 4 * next_cnt);
        end
    end

endmodule

`default_nettype wire

//--- testbench/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam int set_count = 16;
    localparam int line_words = 4;
    localparam int cycles_per_test = set_count + 4 * line_words + 20;

    logic clk;
    logic resetn;
    logic req_valid;
    logic [31:0] req_addr;
    logic req2_valid;
    logic [31:0] req2_addr;
    icache_pkg::icache_op_t op;
    icache_pkg::word_t tag_lo;
    logic addr_ok;
    logic data_ok;
    icache_pkg::fetch_pair_t rdata;
    logic mem_valid;
    logic [31:0] mem_addr;
    logic mem_ready;
    logic mem_last;
    icache_pkg::word_t mem_data;
    logic stall;
    logic [31:0] refill_count;
    logic [31:0] lcg_state;

    // one entry per line of the test file
    logic [31:0] t_op [$];
    logic [31:0] t_valid_1 [$];
    logic [31:0] t_addr_1 [$];
    logic [31:0] t_valid_2 [$];
    logic [31:0] t_addr_2 [$];
    logic [31:0] t_tag_lo [$];
    logic [31:0] t_word_1 [$];
    logic [31:0] t_word_2 [$];
    logic [31:0] t_refills [$];

    int test_count;
    int current_test;
    bit loaded;

    icache #(
        .set_count(set_count),
        .line_words(line_words)
    ) i_icache (
        .clk(clk),
        .resetn(resetn),
        .req_valid(req_valid),
        .req_addr(req_addr),
        .req2_valid(req2_valid),
        .req2_addr(req2_addr),
        .op(op),
        .tag_lo(tag_lo),
        .addr_ok(addr_ok),
        .data_ok(data_ok),
        .rdata(rdata),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .mem_ready(mem_ready),
        .mem_last(mem_last),
        .mem_data(mem_data)
    );

    icache_mem_model #(
        .line_words(line_words)
    ) mem_model (
        .clk(clk),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .stall(stall),
        .mem_ready(mem_ready),
        .mem_last(mem_last),
        .mem_data(mem_data),
        .refill_count(refill_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // roughly one memory cycle in four stalls
    always @(posedge clk) begin
        lcg_state <= lcg_next(lcg_state);
        stall <= (lcg_state[31:30] == 2'b00);
    end

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_pair(input icache_pkg::fetch_pair_t got,
                              input icache_pkg::fetch_pair_t exp,
                              input logic both);
        if (got.word_1 !== exp.word_1) begin
            $display("[FAIL] test %0d rdata.word_1: got %h, expected %h",
                     current_test, got.word_1, exp.word_1);
            stop_run();
        end
        if (both && got.word_2 !== exp.word_2) begin
            $display("[FAIL] test %0d rdata.word_2: got %h, expected %h",
                     current_test, got.word_2, exp.word_2);
            stop_run();
        end
    endtask

    task automatic check_count(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] test %0d refill_count: got %h, expected %h",
                     current_test, got, exp);
            stop_run();
        end
    endtask

    task automatic load_tests();
        int fd;
        int n;
        string line;
        logic [31:0] f [9];
        fd = $fopen("testbench/icache_tests.txt", "r");
        if (fd == 0) begin
            $display("the test file could not be opened");
            stop_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                            f[3], f[4], f[5], f[6], f[7], f[8]);
                if (n == 9) begin
                    t_op.push_back(f[0]);
                    t_valid_1.push_back(f[1]);
                    t_addr_1.push_back(f[2]);
                    t_valid_2.push_back(f[3]);
                    t_addr_2.push_back(f[4]);
                    t_tag_lo.push_back(f[5]);
                    t_word_1.push_back(f[6]);
                    t_word_2.push_back(f[7]);
                    t_refills.push_back(f[8]);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int i);
        logic [31:0] count_before;
        icache_pkg::fetch_pair_t expected;
        current_test = i;
        @(negedge clk);
        count_before = refill_count;
        @(posedge clk);
        req_valid <= t_valid_1[i][0];
        req_addr <= t_addr_1[i];
        req2_valid <= t_valid_2[i][0];
        req2_addr <= t_addr_2[i];
        tag_lo <= t_tag_lo[i];
        op <= icache_pkg::icache_op_t'(t_op[i][2:0]);
        // held until accepted while misses refill
        @(negedge clk);
        while (addr_ok !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        req2_valid <= 1'b0;
        op <= icache_pkg::OP_NONE;
        @(negedge clk);
        if (data_ok !== 1'b1) begin
            $display("test %0d: data_ok did not follow addr_ok by one cycle", i);
            stop_run();
        end
        if (t_op[i][2:0] == icache_pkg::OP_FETCH) begin
            expected.word_1 = t_word_1[i];
            expected.word_2 = t_word_2[i];
            check_pair(rdata, expected, t_valid_2[i][0]);
        end
        check_count(refill_count - count_before, t_refills[i]);
    endtask

    initial begin
        resetn = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req2_valid = 1'b0;
        req2_addr = '0;
        op = icache_pkg::OP_NONE;
        tag_lo = '0;
        stall = 1'b0;
        lcg_state = 32'h6aa3ef69;
        current_test = 0;
        load_tests();
        test_count = t_op.size();
        if (test_count == 0) begin
            $display("the test file holds no tests");
            stop_run();
        end
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        resetn <= 1'b0;
        for (int i = 0; i < test_count; i++) begin
            run_test(i);
        end
        $display("Test passed");
        $finish;
    end

    // budget grows with the number of tests
    initial begin
        wait (loaded);
        repeat (test_count * cycles_per_test) @(posedge clk);
        $display("the cache stopped answering, test %0d not done after %0d cycles",
                 current_test, test_count * cycles_per_test);
        stop_run();
    end

endmodule

`default_nettype wire

//--- testbench/icache_tests.txt
# op valid_1 addr_1 valid_2 addr_2 tag_lo word_1 word_2 refills (all hex)
# op: 0 fetch, 1 index invalidate, 2 hit invalidate, 3 index store tag
0 1 00001004 0 00000000 00000000 c0de1004 00000000 1
0 1 0000100c 0 00000000 00000000 c0de100c 00000000 0
0 1 00002028 0 00000000 00000000 c0de2028 00000000 1
0 1 00001000 1 00002024 00000000 c0de1000 c0de2024 0
0 1 00001008 1 00003034 00000000 c0de1008 c0de3034 1
0 1 00004040 1 00005050 00000000 c0de4040 c0de5050 2
# set 6 replacement with tags 100, 200, 300
0 1 00010060 0 00000000 00000000 c0df0060 00000000 1
0 1 00020064 0 00000000 00000000 c0dc0064 00000000 1
0 1 00010060 0 00000000 00000000 c0df0060 00000000 0
0 1 00030068 0 00000000 00000000 c0dd0068 00000000 1
0 1 00010060 0 00000000 00000000 c0df0060 00000000 0
0 1 00020064 0 00000000 00000000 c0dc0064 00000000 1
# invalidate by hit, then by index and way
2 1 00001004 0 00000000 00000000 00000000 00000000 0
0 1 00001004 0 00000000 00000000 c0de1004 00000000 1
1 1 00000060 0 00000000 00000000 00000000 00000000 0
0 1 00010060 0 00000000 00000000 c0df0060 00000000 1
1 1 00000160 0 00000000 00000000 00000000 00000000 0
0 1 00020064 0 00000000 00000000 c0dc0064 00000000 1
0 1 00010060 0 00000000 00000000 c0df0060 00000000 0
# store tag, valid clear then a chosen tag on stale data
3 1 00000020 0 00000000 00000000 00000000 00000000 0
0 1 00002028 0 00000000 00000000 c0de2028 00000000 1
3 1 00000030 0 00000000 00007701 00000000 00000000 0
0 1 00007734 0 00000000 00000000 c0de3034 00000000 0
0 1 00003034 0 00000000 00000000 c0de3034 00000000 1
0 1 00007738 0 00000000 00000000 c0de3038 00000000 0
